// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fabric_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
verilog/bus_pkg.sv
verilog/read_arbiter.sv
verilog/read_router.sv
verilog/clint_timer.sv
verilog/mem_fabric.sv
verif/fabric_tb.sv

// ==== verif/fabric_tb.sv ====
module fabric_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;

    localparam logic [31:0] data_key   = 32'h5a5a_0000;
    localparam int          wait_limit = 200;

    typedef enum int {
        ev_fetch_ar, ev_lsu_ar, ev_fetch_r, ev_lsu_r, ev_aw, ev_w, ev_b
    } hs_event_t;

    logic       clock = 1'b0;
    logic       arst_n;
    logic       fetch_arvalid, fetch_arready;
    axi_addr_t  fetch_ar;
    logic       fetch_rvalid, fetch_rready;
    axi_rdata_t fetch_r;
    logic       lsu_arvalid, lsu_arready;
    axi_addr_t  lsu_ar;
    logic       lsu_rvalid, lsu_rready;
    axi_rdata_t lsu_r;
    logic       lsu_awvalid, lsu_awready;
    axi_addr_t  lsu_aw;
    logic       lsu_wvalid, lsu_wready;
    axi_wdata_t lsu_w;
    logic       lsu_bvalid, lsu_bready;
    axi_bresp_t lsu_b;

    // master side inputs belong to the memory model
    logic       mst_arvalid;
    logic       mst_arready = 1'b0;
    axi_addr_t  mst_ar;
    logic       mst_rvalid = 1'b0;
    logic       mst_rready;
    axi_rdata_t mst_r = '0;
    logic       mst_awvalid;
    logic       mst_awready = 1'b0;
    axi_addr_t  mst_aw;
    logic       mst_wvalid;
    logic       mst_wready = 1'b0;
    axi_wdata_t mst_w;
    logic       mst_bvalid = 1'b0;
    logic       mst_bready;
    axi_bresp_t mst_b = '0;

    // expected values change on falling edges only
    axi_addr_t   exp_mst_ar = '0;
    axi_addr_t   exp_aw = '0;
    axi_wdata_t  exp_w = '0;
    axi_bresp_t  exp_b = '0;
    axi_rdata_t  exp_fetch_r = '0;
    axi_rdata_t  exp_lsu_r = '0;
    logic        fetch_wait = 1'b0;
    logic        lsu_wait = 1'b0;
    logic        tmr_phase = 1'b0;
    logic        tmr_incr = 1'b0;
    logic [31:0] last_tmr = '0;
    logic        ar_stall = 1'b0;
    int          errors = 0;
    int          tests = 0;
    int          err_mark = 0;

    // handshakes seen on the last rising edge
    logic        fetch_ar_fire = 1'b0;
    logic        lsu_ar_fire = 1'b0;
    logic        fetch_r_done = 1'b0;
    logic        lsu_r_done = 1'b0;
    axi_rdata_t  lsu_r_q = '0;
    logic        lsu_aw_fire = 1'b0;
    logic        lsu_w_fire = 1'b0;
    logic        lsu_b_fire = 1'b0;
    logic        mst_ar_fire = 1'b0;
    logic        mst_arvalid_q = 1'b0;
    axi_addr_t   mst_ar_q = '0;
    logic        mst_r_fire = 1'b0;
    logic        mst_aw_fire = 1'b0;
    axi_addr_t   mst_aw_q = '0;
    logic        mst_w_fire = 1'b0;
    logic        mst_b_fire = 1'b0;

    int          ar_delay = 0;
    logic        aw_got = 1'b0;
    logic        w_got = 1'b0;
    logic [3:0]  aw_id = '0;
    logic [11:0] hs_out;

    assign hs_out = {fetch_arready, fetch_rvalid, lsu_arready, lsu_rvalid, lsu_awready,
                     lsu_wready, lsu_bvalid, mst_arvalid, mst_rready, mst_awvalid,
                     mst_wvalid, mst_bready};

    mem_fabric u_dut (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        fetch_ar_fire <= fetch_arvalid && fetch_arready;
        lsu_ar_fire   <= lsu_arvalid && lsu_arready;
        fetch_r_done  <= fetch_rvalid && fetch_rready && fetch_r.last;
        lsu_r_done    <= lsu_rvalid && lsu_rready && lsu_r.last;
        lsu_r_q       <= lsu_r;
        lsu_aw_fire   <= lsu_awvalid && lsu_awready;
        lsu_w_fire    <= lsu_wvalid && lsu_wready;
        lsu_b_fire    <= lsu_bvalid && lsu_bready;
        mst_ar_fire   <= mst_arvalid && mst_arready;
        mst_arvalid_q <= mst_arvalid;
        mst_ar_q      <= mst_ar;
        mst_r_fire    <= mst_rvalid && mst_rready;
        mst_aw_fire   <= mst_awvalid && mst_awready;
        mst_aw_q      <= mst_aw;
        mst_w_fire    <= mst_wvalid && mst_wready;
        mst_b_fire    <= mst_bvalid && mst_bready;
    end

    // memory model on the master port
    always @(negedge clock) begin
        if (arst_n) begin
            if (mst_r_fire) begin
                mst_rvalid = 1'b0;
            end
            if (mst_ar_fire) begin
                mst_arready = 1'b0;
                mst_rvalid  = 1'b1;
                mst_r       = '{data: mst_ar_q.addr ^ data_key, resp: resp_okay,
                                last: 1'b1, id: mst_ar_q.id};
                ar_delay    = $urandom_range(3, 0);
            end else if (mst_arvalid_q && !mst_arready && !mst_rvalid && !ar_stall) begin
                if (ar_delay == 0) begin
                    mst_arready = 1'b1;
                end else begin
                    ar_delay = ar_delay - 1;
                end
            end
            if (mst_aw_fire) begin
                aw_got = 1'b1;
                aw_id  = mst_aw_q.id;
            end
            if (mst_w_fire) begin
                w_got = 1'b1;
            end
            if (mst_b_fire) begin
                mst_bvalid = 1'b0;
                aw_got     = 1'b0;
                w_got      = 1'b0;
            end else if (aw_got && w_got && !mst_bvalid) begin
                mst_bvalid = 1'b1;
                mst_b      = '{resp: resp_okay, id: aw_id};
            end
            mst_awready = !aw_got && !mst_bvalid;
            mst_wready  = !w_got && !mst_bvalid;
        end
    end

    a_reset_quiet: assert property (
        @(posedge clock) !arst_n |-> hs_out == '0
    ) else value_error("reset handshake outputs", '0, 64'($sampled(hs_out)));

    a_mst_ar: assert property (
        @(posedge clock) disable iff (!arst_n) mst_arvalid |-> mst_ar == exp_mst_ar
    ) else value_error("mst_ar", 64'(exp_mst_ar), 64'($sampled(mst_ar)));

    a_fetch_r: assert property (
        @(posedge clock) disable iff (!arst_n) fetch_rvalid |-> fetch_r == exp_fetch_r
    ) else value_error("fetch_r", 64'(exp_fetch_r), 64'($sampled(fetch_r)));

    a_lsu_r: assert property (
        @(posedge clock) disable iff (!arst_n) lsu_rvalid && !tmr_incr |-> lsu_r == exp_lsu_r
    ) else value_error("lsu_r", 64'(exp_lsu_r), 64'($sampled(lsu_r)));

    a_fetch_idle: assert property (
        @(posedge clock) disable iff (!arst_n) !fetch_wait |-> !fetch_rvalid
    ) else report_fault("fetch rvalid rose with no fetch read outstanding");

    a_lsu_idle: assert property (
        @(posedge clock) disable iff (!arst_n) !lsu_wait |-> !lsu_rvalid
    ) else report_fault("lsu rvalid rose with no lsu read outstanding");

    // mtime must have moved on since the previous read
    a_tmr_incr: assert property (
        @(posedge clock) disable iff (!arst_n)
        lsu_rvalid && tmr_incr |-> lsu_r.data > last_tmr && lsu_r.last
            && lsu_r.resp == resp_okay && lsu_r.id == exp_lsu_r.id
    ) else begin
        $display("error at %0t: lsu_r.data expected above %h, got %h (id %h last %b)",
                 $time, last_tmr, $sampled(lsu_r.data), $sampled(lsu_r.id),
                 $sampled(lsu_r.last));
        errors++;
    end

    a_tmr_no_mst: assert property (
        @(posedge clock) disable iff (!arst_n) tmr_phase |-> !mst_arvalid
    ) else report_fault("timer read leaked onto the master address channel");

    a_aw: assert property (
        @(posedge clock) disable iff (!arst_n) mst_awvalid |-> mst_aw == exp_aw
    ) else value_error("mst_aw", 64'(exp_aw), 64'($sampled(mst_aw)));

    a_w: assert property (
        @(posedge clock) disable iff (!arst_n) mst_wvalid |-> mst_w == exp_w
    ) else value_error("mst_w", 64'(exp_w), 64'($sampled(mst_w)));

    a_b: assert property (
        @(posedge clock) disable iff (!arst_n) lsu_bvalid |-> lsu_b == exp_b
    ) else value_error("lsu_b", 64'(exp_b), 64'($sampled(lsu_b)));

    a_stall_ready: assert property (
        @(posedge clock) disable iff (!arst_n)
        mst_arvalid && !mst_arready |-> !fetch_arready && !lsu_arready
    ) else report_fault("requester saw arready while the master port stalled");

    a_stall_stable: assert property (
        @(posedge clock) disable iff (!arst_n)
        mst_arvalid && !mst_arready |=> mst_arvalid && $stable(mst_ar)
    ) else report_fault("mst_ar dropped or changed while waiting for arready");

    task automatic value_error(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        $display("error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("failure at %0t: %s", $time, what);
        errors++;
    endtask

    function automatic bit fired(input hs_event_t ev);
        case (ev)
            ev_fetch_ar: return fetch_ar_fire;
            ev_lsu_ar:   return lsu_ar_fire;
            ev_fetch_r:  return fetch_r_done;
            ev_lsu_r:    return lsu_r_done;
            ev_aw:       return lsu_aw_fire;
            ev_w:        return lsu_w_fire;
            ev_b:        return lsu_b_fire;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic wait_fire(input hs_event_t ev, input string what);
        int cnt;
        bit hit;
        cnt = 0;
        hit = 1'b0;
        while (!hit && cnt < wait_limit) begin
            @(negedge clock);
            cnt++;
            hit = fired(ev);
        end
        if (!hit) begin
            $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
            errors++;
        end
    endtask

    function automatic axi_addr_t mem_req();
        logic [31:0] rnd;
        rnd = $urandom;
        // upper nibble 1 keeps it clear of the timer window
        return '{addr: {4'h1, rnd[27:2], 2'b00}, id: rnd[31:28], len: '0,
                 size: 3'd2, burst: 2'b01};
    endfunction

    function automatic axi_addr_t tmr_req(input logic [15:0] off);
        logic [31:0] rnd;
        rnd = $urandom;
        return '{addr: clint_base | {16'h0, off}, id: rnd[3:0], len: '0,
                 size: 3'd2, burst: 2'b01};
    endfunction

    task automatic issue_read(input bit lsu, input axi_addr_t req, input logic [31:0] data);
        axi_rdata_t beat;
        beat = '{data: data, resp: resp_okay, last: 1'b1, id: req.id};
        if (lsu) begin
            exp_lsu_r   = beat;
            lsu_wait    = 1'b1;
            lsu_ar      = req;
            lsu_arvalid = 1'b1;
        end else begin
            exp_fetch_r   = beat;
            fetch_wait    = 1'b1;
            fetch_ar      = req;
            fetch_arvalid = 1'b1;
        end
    endtask

    task automatic finish_read(input bit lsu);
        if (lsu) begin
            wait_fire(ev_lsu_ar, "lsu read address handshake");
            lsu_arvalid = 1'b0;
            wait_fire(ev_lsu_r, "lsu read response");
            lsu_wait = 1'b0;
        end else begin
            wait_fire(ev_fetch_ar, "fetch read address handshake");
            fetch_arvalid = 1'b0;
            wait_fire(ev_fetch_r, "fetch read response");
            fetch_wait = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        axi_addr_t  req_f;
        axi_addr_t  req_l;
        axi_wdata_t wr;
        void'($urandom(32'hfb01_00ec));
        arst_n        = 1'b0;
        fetch_arvalid = 1'b0;
        fetch_ar      = '0;
        fetch_rready  = 1'b0;
        lsu_arvalid   = 1'b0;
        lsu_ar        = '0;
        lsu_rready    = 1'b0;
        lsu_awvalid   = 1'b0;
        lsu_aw        = '0;
        lsu_wvalid    = 1'b0;
        lsu_w         = '0;
        lsu_bready    = 1'b0;
        repeat (10) @(negedge clock);
        arst_n       = 1'b1;
        fetch_rready = 1'b1;
        lsu_rready   = 1'b1;
        lsu_bready   = 1'b1;
        finish_test("reset state");

        repeat (3) begin
            req_f      = mem_req();
            exp_mst_ar = req_f;
            issue_read(1'b0, req_f, req_f.addr ^ data_key);
            finish_read(1'b0);
        end
        finish_test("fetch read");

        // lsu wins a same-cycle tie
        req_f      = mem_req();
        req_l      = mem_req();
        exp_mst_ar = req_l;
        issue_read(1'b0, req_f, req_f.addr ^ data_key);
        issue_read(1'b1, req_l, req_l.addr ^ data_key);
        finish_read(1'b1);
        exp_mst_ar = req_f;
        finish_read(1'b0);
        finish_test("requester tie");

        req_l       = mem_req();
        wr          = '{data: $urandom, strb: 4'hf, last: 1'b1};
        exp_aw      = req_l;
        exp_w       = wr;
        exp_b       = '{resp: resp_okay, id: req_l.id};
        lsu_aw      = req_l;
        lsu_awvalid = 1'b1;
        wait_fire(ev_aw, "lsu write address handshake");
        lsu_awvalid = 1'b0;
        lsu_w       = wr;
        lsu_wvalid  = 1'b1;
        wait_fire(ev_w, "lsu write data handshake");
        lsu_wvalid = 1'b0;
        wait_fire(ev_b, "lsu write response");
        finish_test("write pass-through");

        tmr_phase = 1'b1;
        req_l     = tmr_req(mtime_hi_off);
        issue_read(1'b1, req_l, 32'h0);
        finish_read(1'b1);
        tmr_incr = 1'b1;
        last_tmr = '0;
        repeat (2) begin
            req_l = tmr_req(mtime_lo_off);
            issue_read(1'b1, req_l, 32'h0);
            finish_read(1'b1);
            last_tmr = lsu_r_q.data;
        end
        tmr_incr  = 1'b0;
        tmr_phase = 1'b0;
        finish_test("timer reads");

        ar_stall   = 1'b1;
        req_f      = mem_req();
        exp_mst_ar = req_f;
        issue_read(1'b0, req_f, req_f.addr ^ data_key);
        repeat (8) @(negedge clock);
        ar_stall = 1'b0;
        finish_read(1'b0);
        finish_test("back-pressure");

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;
    localparam int strb_w = 4;

    localparam logic [1:0] resp_okay = 2'b00;

    // 64 KiB timer window
    localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;
    localparam logic [addr_w-1:0] clint_mask = 32'hffff_0000;

    // word offsets inside the window
    localparam logic [15:0] mtime_lo_off = 16'h0000;
    localparam logic [15:0] mtime_hi_off = 16'h0004;

    // shared by ar and aw
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
        logic [len_w-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_addr_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic [id_w-1:0]   id;
    } axi_rdata_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_wdata_t;

    typedef struct packed {
        logic [1:0]      resp;
        logic [id_w-1:0] id;
    } axi_bresp_t;

    // who owns the outstanding read
    typedef enum logic {
        owner_fetch = 1'b0,
        owner_lsu   = 1'b1
    } rd_owner_t;

endpackage

// ==== verilog/clint_timer.sv ====
module clint_timer (
    input  logic                clock,
    input  logic                arst_n,

    input  logic                arvalid,
    output logic                arready,
    input  bus_pkg::axi_addr_t  ar,
    output logic                rvalid,
    input  logic                rready,
    output bus_pkg::axi_rdata_t r
);
    import bus_pkg::*;

    logic [63:0]       mtime;
    logic [data_w-1:0] rdata_q;
    logic [id_w-1:0]   rid_q;
    logic [data_w-1:0] rd_word;

    // free running machine timer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_comb begin
        if (ar.addr[15:0] == mtime_lo_off) begin
            rd_word = mtime[31:0];
        end else if (ar.addr[15:0] == mtime_hi_off) begin
            rd_word = mtime[63:32];
        end else begin
            rd_word = '0;
        end
    end

    assign arready = !rvalid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // payload captured on accept and held until taken
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rdata_q <= rd_word;
            rid_q   <= ar.id;
        end
    end

    assign r = '{data: rdata_q, resp: resp_okay, last: 1'b1, id: rid_q};

    a_resp_after_accept: assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(rvalid) |-> $past(arvalid && arready)
    );

endmodule

// ==== verilog/mem_fabric.sv ====
module mem_fabric (
    input  logic                clock,
    input  logic                arst_n,

    input  logic                fetch_arvalid,
    output logic                fetch_arready,
    input  bus_pkg::axi_addr_t  fetch_ar,
    output logic                fetch_rvalid,
    input  logic                fetch_rready,
    output bus_pkg::axi_rdata_t fetch_r,

    input  logic                lsu_arvalid,
    output logic                lsu_arready,
    input  bus_pkg::axi_addr_t  lsu_ar,
    output logic                lsu_rvalid,
    input  logic                lsu_rready,
    output bus_pkg::axi_rdata_t lsu_r,
    input  logic                lsu_awvalid,
    output logic                lsu_awready,
    input  bus_pkg::axi_addr_t  lsu_aw,
    input  logic                lsu_wvalid,
    output logic                lsu_wready,
    input  bus_pkg::axi_wdata_t lsu_w,
    output logic                lsu_bvalid,
    input  logic                lsu_bready,
    output bus_pkg::axi_bresp_t lsu_b,

    output logic                mst_arvalid,
    input  logic                mst_arready,
    output bus_pkg::axi_addr_t  mst_ar,
    input  logic                mst_rvalid,
    output logic                mst_rready,
    input  bus_pkg::axi_rdata_t mst_r,
    output logic                mst_awvalid,
    input  logic                mst_awready,
    output bus_pkg::axi_addr_t  mst_aw,
    output logic                mst_wvalid,
    input  logic                mst_wready,
    output bus_pkg::axi_wdata_t mst_w,
    input  logic                mst_bvalid,
    output logic                mst_bready,
    input  bus_pkg::axi_bresp_t mst_b
);
    import bus_pkg::*;

    logic       gnt_arvalid;
    logic       gnt_arready;
    axi_addr_t  gnt_ar;
    logic       gnt_rvalid;
    logic       gnt_rready;
    axi_rdata_t gnt_r;

    logic       tmr_arvalid;
    logic       tmr_arready;
    axi_addr_t  tmr_ar;
    logic       tmr_rvalid;
    logic       tmr_rready;
    axi_rdata_t tmr_r;

    // writes go straight to the master port
    assign mst_awvalid = lsu_awvalid;
    assign lsu_awready = mst_awready;
    assign mst_aw      = lsu_aw;
    assign mst_wvalid  = lsu_wvalid;
    assign lsu_wready  = mst_wready;
    assign mst_w       = lsu_w;
    assign lsu_bvalid  = mst_bvalid;
    assign mst_bready  = lsu_bready;
    assign lsu_b       = mst_b;

    read_arbiter u_arbiter (
        .clock         (clock),
        .arst_n        (arst_n),
        .fetch_arvalid (fetch_arvalid),
        .fetch_arready (fetch_arready),
        .fetch_ar      (fetch_ar),
        .fetch_rvalid  (fetch_rvalid),
        .fetch_rready  (fetch_rready),
        .fetch_r       (fetch_r),
        .lsu_arvalid   (lsu_arvalid),
        .lsu_arready   (lsu_arready),
        .lsu_ar        (lsu_ar),
        .lsu_rvalid    (lsu_rvalid),
        .lsu_rready    (lsu_rready),
        .lsu_r         (lsu_r),
        .gnt_arvalid   (gnt_arvalid),
        .gnt_arready   (gnt_arready),
        .gnt_ar        (gnt_ar),
        .gnt_rvalid    (gnt_rvalid),
        .gnt_rready    (gnt_rready),
        .gnt_r         (gnt_r)
    );

    read_router u_router (
        .clock       (clock),
        .arst_n      (arst_n),
        .arvalid     (gnt_arvalid),
        .arready     (gnt_arready),
        .ar          (gnt_ar),
        .rvalid      (gnt_rvalid),
        .rready      (gnt_rready),
        .r           (gnt_r),
        .mst_arvalid (mst_arvalid),
        .mst_arready (mst_arready),
        .mst_ar      (mst_ar),
        .mst_rvalid  (mst_rvalid),
        .mst_rready  (mst_rready),
        .mst_r       (mst_r),
        .tmr_arvalid (tmr_arvalid),
        .tmr_arready (tmr_arready),
        .tmr_ar      (tmr_ar),
        .tmr_rvalid  (tmr_rvalid),
        .tmr_rready  (tmr_rready),
        .tmr_r       (tmr_r)
    );

    clint_timer u_clint (
        .clock   (clock),
        .arst_n  (arst_n),
        .arvalid (tmr_arvalid),
        .arready (tmr_arready),
        .ar      (tmr_ar),
        .rvalid  (tmr_rvalid),
        .rready  (tmr_rready),
        .r       (tmr_r)
    );

endmodule

// ==== verilog/read_arbiter.sv ====
module read_arbiter (
    input  logic                clock,
    input  logic                arst_n,

    input  logic                fetch_arvalid,
    output logic                fetch_arready,
    input  bus_pkg::axi_addr_t  fetch_ar,
    output logic                fetch_rvalid,
    input  logic                fetch_rready,
    output bus_pkg::axi_rdata_t fetch_r,

    input  logic                lsu_arvalid,
    output logic                lsu_arready,
    input  bus_pkg::axi_addr_t  lsu_ar,
    output logic                lsu_rvalid,
    input  logic                lsu_rready,
    output bus_pkg::axi_rdata_t lsu_r,

    output logic                gnt_arvalid,
    input  logic                gnt_arready,
    output bus_pkg::axi_addr_t  gnt_ar,
    input  logic                gnt_rvalid,
    output logic                gnt_rready,
    input  bus_pkg::axi_rdata_t gnt_r
);
    import bus_pkg::*;

    logic      busy;
    logic      hold;
    rd_owner_t owner;
    rd_owner_t pick;
    logic      ar_fire;
    logic      r_done;

    // a stalled request keeps its pick so the forwarded address stays put
    always_comb begin
        if (hold) begin
            pick = owner;
        end else if (lsu_arvalid) begin
            pick = owner_lsu;
        end else begin
            pick = owner_fetch;
        end
    end

    assign gnt_arvalid = !busy && (fetch_arvalid || lsu_arvalid);
    assign gnt_ar      = (pick == owner_lsu) ? lsu_ar : fetch_ar;

    // loser never sees ready
    assign lsu_arready   = !busy && lsu_arvalid && (pick == owner_lsu) && gnt_arready;
    assign fetch_arready = !busy && fetch_arvalid && (pick == owner_fetch) && gnt_arready;

    assign ar_fire = gnt_arvalid && gnt_arready;

    // response demux by locked owner
    assign fetch_rvalid = busy && (owner == owner_fetch) && gnt_rvalid;
    assign lsu_rvalid   = busy && (owner == owner_lsu) && gnt_rvalid;
    assign fetch_r      = gnt_r;
    assign lsu_r        = gnt_r;
    assign gnt_rready   = busy && ((owner == owner_lsu) ? lsu_rready : fetch_rready);

    assign r_done = gnt_rvalid && gnt_rready && gnt_r.last;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            hold  <= 1'b0;
            owner <= owner_fetch;
        end else begin
            if (ar_fire) begin
                busy <= 1'b1;
            end else if (r_done) begin
                busy <= 1'b0;
            end
            hold <= gnt_arvalid && !gnt_arready;
            // only moves while unlocked
            if (gnt_arvalid) begin
                owner <= pick;
            end
        end
    end

    // router must stay quiet until a read is granted
    a_no_resp_idle: assert property (
        @(posedge clock) disable iff (!arst_n)
        !busy |-> !gnt_rvalid
    );

    a_ar_stable: assert property (
        @(posedge clock) disable iff (!arst_n)
        gnt_arvalid && !gnt_arready |=> gnt_arvalid && $stable(gnt_ar)
    );

endmodule

// ==== verilog/read_router.sv ====
module read_router (
    input  logic                clock,
    input  logic                arst_n,

    input  logic                arvalid,
    output logic                arready,
    input  bus_pkg::axi_addr_t  ar,
    output logic                rvalid,
    input  logic                rready,
    output bus_pkg::axi_rdata_t r,

    output logic                mst_arvalid,
    input  logic                mst_arready,
    output bus_pkg::axi_addr_t  mst_ar,
    input  logic                mst_rvalid,
    output logic                mst_rready,
    input  bus_pkg::axi_rdata_t mst_r,

    output logic                tmr_arvalid,
    input  logic                tmr_arready,
    output bus_pkg::axi_addr_t  tmr_ar,
    input  logic                tmr_rvalid,
    output logic                tmr_rready,
    input  bus_pkg::axi_rdata_t tmr_r
);
    import bus_pkg::*;

    logic hit_tmr;
    logic pending;
    logic sel_tmr;
    logic r_done;

    // address decode is only meaningful while idle
    assign hit_tmr = (ar.addr & clint_mask) == clint_base;

    assign tmr_arvalid = !pending && arvalid && hit_tmr;
    assign mst_arvalid = !pending && arvalid && !hit_tmr;
    assign arready     = !pending && (hit_tmr ? tmr_arready : mst_arready);
    assign mst_ar      = ar;
    assign tmr_ar      = ar;

    // response from the recorded target only
    assign rvalid     = pending && (sel_tmr ? tmr_rvalid : mst_rvalid);
    assign r          = sel_tmr ? tmr_r : mst_r;
    assign mst_rready = pending && !sel_tmr && rready;
    assign tmr_rready = pending && sel_tmr && rready;

    assign r_done = rvalid && rready && r.last;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            sel_tmr <= 1'b0;
        end else if (arvalid && arready) begin
            pending <= 1'b1;
            sel_tmr <= hit_tmr;
        end else if (r_done) begin
            pending <= 1'b0;
        end
    end

    a_one_target: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(mst_arvalid && tmr_arvalid)
    );

    // timer only answers reads routed to it
    a_tmr_owned: assert property (
        @(posedge clock) disable iff (!arst_n)
        tmr_rvalid |-> pending && sel_tmr
    );

endmodule
